// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mx_cast
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN)

check: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
+incdir+include
logic/mx_pkg.sv
logic/mx_log2_max_abs.sv
logic/mx_stream_fifo.sv
logic/mx_skid_buffer.sv
logic/mxint_cast.sv
logic/mx_cast_top.sv
testbench/tb_mx_cast.sv

// ==== logic/mx_cast_top.sv ====
`timescale 1ns/1ps

module mx_cast_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  mx_pkg::in_block_t  in_block,
  output logic               out_valid,
  input  logic               out_ready,
  output mx_pkg::out_block_t out_block
);

  logic               cast_valid;
  logic               cast_ready;
  mx_pkg::out_block_t cast_block;

  mxint_cast u_cast (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_block  (in_block),
    .out_valid (cast_valid),
    .out_ready (cast_ready),
    .out_block (cast_block)
  );

  // registered slice so out_ready does not reach the cast logic
  mx_skid_buffer #(
    .payload_t (mx_pkg::out_block_t)
  ) u_out_slice (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (cast_valid),
    .in_ready  (cast_ready),
    .in_data   (cast_block),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_block)
  );

endmodule

// ==== logic/mx_log2_max_abs.sv ====
`timescale 1ns/1ps

module mx_log2_max_abs (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     in_valid,
  output logic                                     in_ready,
  input  mx_pkg::in_man_t [mx_pkg::BLOCK_SIZE-1:0] in_man,
  output logic                                     out_valid,
  input  logic                                     out_ready,
  output mx_pkg::log2_t                            out_log2
);

  logic [mx_pkg::IN_MAN_WIDTH-1:0] abs_v [mx_pkg::BLOCK_SIZE];
  // heap layout, root at 0, leaves from BLOCK_SIZE-1 upwards
  logic [mx_pkg::IN_MAN_WIDTH-1:0] tree [2*mx_pkg::BLOCK_SIZE-1];
  logic [mx_pkg::IN_MAN_WIDTH-1:0] max_q;
  mx_pkg::log2_t                   lead_c;
  logic                            s1_valid;
  logic                            en;

  // whole pipeline moves when the last stage is free or drained
  assign en       = !out_valid || out_ready;
  assign in_ready = en;

  always_comb begin
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      // -128 maps to 8'h80, still correct as unsigned
      abs_v[i] = in_man[i][mx_pkg::IN_MAN_WIDTH-1] ? -in_man[i] : in_man[i];
      tree[mx_pkg::BLOCK_SIZE-1+i] = abs_v[i];
    end
    for (int k = mx_pkg::BLOCK_SIZE - 2; k >= 0; k--) begin
      tree[k] = (tree[2*k+1] > tree[2*k+2]) ? tree[2*k+1] : tree[2*k+2];
    end
  end

  // leading one of the registered maximum, 0 for an all-zero block
  always_comb begin
    lead_c = '0;
    for (int b = 0; b < mx_pkg::IN_MAN_WIDTH; b++) begin
      if (max_q[b]) begin
        lead_c = mx_pkg::log2_t'(b);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (en) begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      max_q    <= tree[0];
      out_log2 <= lead_c;
    end
  end

  a_log2_range: assert property (
    @(posedge clk) disable iff (rst)
    out_valid |-> (out_log2 >= 0 && out_log2 <= mx_pkg::IN_MAN_WIDTH - 1)
  ) else $error("log2 position out of mantissa range");

endmodule

// ==== logic/mx_pkg.sv ====
package mx_pkg;

  // input block format
  localparam int IN_MAN_WIDTH = 8;
  localparam int IN_MAN_FRAC_WIDTH = 7;
  localparam int IN_EXP_WIDTH = 6;

  // output block format
  localparam int OUT_MAN_WIDTH = 4;
  localparam int OUT_EXP_WIDTH = 5;

  localparam int BLOCK_SIZE = 4;
  localparam int LOG2_WIDTH = $clog2(IN_MAN_WIDTH) + 1;
  localparam int BUF_DEPTH = 4;

  // working widths for the exponent sum and the mantissa shift
  localparam int EXP_FULL_WIDTH = IN_EXP_WIDTH + 2;
  localparam int CAST_WIDTH = IN_MAN_WIDTH + 16;

  typedef logic signed [IN_MAN_WIDTH-1:0] in_man_t;
  typedef logic signed [IN_EXP_WIDTH-1:0] in_exp_t;
  typedef logic signed [OUT_MAN_WIDTH-1:0] out_man_t;
  typedef logic signed [OUT_EXP_WIDTH-1:0] out_exp_t;
  typedef logic signed [LOG2_WIDTH-1:0] log2_t;
  typedef logic signed [EXP_FULL_WIDTH-1:0] exp_full_t;
  typedef logic signed [CAST_WIDTH-1:0] cast_t;

  typedef struct packed {
    in_man_t [BLOCK_SIZE-1:0] man;
    in_exp_t exp;
  } in_block_t;

  typedef struct packed {
    out_man_t [BLOCK_SIZE-1:0] man;
    out_exp_t exp;
  } out_block_t;

  // saturate to the range of a signed number of the given width
  function automatic int signed_clamp(input int value, input int width);
    int max_v;
    int min_v;
    max_v = (1 <<< (width - 1)) - 1;
    min_v = -(1 <<< (width - 1));
    if (value > max_v) begin
      return max_v;
    end else if (value < min_v) begin
      return min_v;
    end
    return value;
  endfunction

endpackage

// ==== logic/mx_skid_buffer.sv ====
`timescale 1ns/1ps

module mx_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t skid_data;
  logic     skid_valid;
  logic     in_xfer;
  logic     main_free;

  assign in_xfer   = in_valid && in_ready;
  assign main_free = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else if (main_free) begin
      // skid entry drains first, in_ready is low while it is held
      out_valid  <= skid_valid || in_xfer;
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
      in_ready   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        out_data <= skid_data;
      end else if (in_xfer) begin
        out_data <= in_data;
      end
    end else if (in_xfer) begin
      skid_data <= in_data;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("output block changed while stalled");

endmodule

// ==== logic/mx_stream_fifo.sv ====
`timescale 1ns/1ps

module mx_stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       wr;
  logic                       rd;

  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != 0);
  assign out_data  = mem[rd_ptr];

  assign wr = in_valid && in_ready;
  assign rd = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (wr && !rd) begin
        count <= count + 1'b1;
      end else if (rd && !wr) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= in_data;
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    count <= DEPTH
  ) else $error("fifo written while full");

  // an underflow would leave the pointers apart with nothing stored
  a_no_underflow: assert property (
    @(posedge clk) disable iff (rst)
    (count == 0) |-> (wr_ptr == rd_ptr)
  ) else $error("fifo read while empty");

endmodule

// ==== logic/mxint_cast.sv ====
`timescale 1ns/1ps

module mxint_cast (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  mx_pkg::in_block_t  in_block,
  output logic               out_valid,
  input  logic               out_ready,
  output mx_pkg::out_block_t out_block
);

  // split side
  logic log_in_valid;
  logic log_in_ready;
  logic fifo_in_valid;
  logic fifo_in_ready;

  // join side
  mx_pkg::log2_t     log_out;
  logic              log_out_valid;
  logic              log_out_ready;
  mx_pkg::in_block_t buf_block;
  logic              fifo_out_valid;
  logic              fifo_out_ready;

  // exponent and shift arithmetic
  mx_pkg::exp_full_t                 exp_full;
  mx_pkg::out_exp_t                  exp_out;
  mx_pkg::exp_full_t                 shift;
  logic [mx_pkg::EXP_FULL_WIDTH-1:0] shift_abs;
  mx_pkg::cast_t                     man_wide [mx_pkg::BLOCK_SIZE];
  mx_pkg::cast_t                     man_shift [mx_pkg::BLOCK_SIZE];

  // offer to each branch only when the other can take it too
  assign in_ready      = log_in_ready && fifo_in_ready;
  assign log_in_valid  = in_valid && fifo_in_ready;
  assign fifo_in_valid = in_valid && log_in_ready;

  mx_log2_max_abs u_log2 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (log_in_valid),
    .in_ready  (log_in_ready),
    .in_man    (in_block.man),
    .out_valid (log_out_valid),
    .out_ready (log_out_ready),
    .out_log2  (log_out)
  );

  mx_stream_fifo #(
    .payload_t (mx_pkg::in_block_t),
    .DEPTH     (mx_pkg::BUF_DEPTH)
  ) u_buf (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .in_data   (in_block),
    .out_valid (fifo_out_valid),
    .out_ready (fifo_out_ready),
    .out_data  (buf_block)
  );

  // join, both heads pop on the same transfer
  assign out_valid      = log_out_valid && fifo_out_valid;
  assign log_out_ready  = out_ready && fifo_out_valid;
  assign fifo_out_ready = out_ready && log_out_valid;

  always_comb begin
    exp_full = mx_pkg::exp_full_t'(log_out) + mx_pkg::exp_full_t'(buf_block.exp)
             - mx_pkg::exp_full_t'(mx_pkg::IN_MAN_FRAC_WIDTH);
    exp_out  = mx_pkg::out_exp_t'(mx_pkg::signed_clamp(int'(exp_full),
                                                        mx_pkg::OUT_EXP_WIDTH));
    // positive shift drops bits, negative shift scales up
    shift    = mx_pkg::exp_full_t'(exp_out) - mx_pkg::exp_full_t'(buf_block.exp)
             + mx_pkg::exp_full_t'(mx_pkg::IN_MAN_FRAC_WIDTH - (mx_pkg::OUT_MAN_WIDTH - 1));
    shift_abs = shift[mx_pkg::EXP_FULL_WIDTH-1] ? -shift : shift;
  end

  always_comb begin
    out_block.exp = exp_out;
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      man_wide[i] = mx_pkg::cast_t'(buf_block.man[i]);
      if (shift[mx_pkg::EXP_FULL_WIDTH-1]) begin
        man_shift[i] = man_wide[i] <<< shift_abs;
      end else begin
        man_shift[i] = man_wide[i] >>> shift_abs;
      end
      out_block.man[i] = mx_pkg::out_man_t'(mx_pkg::signed_clamp(int'(man_shift[i]),
                                                                 mx_pkg::OUT_MAN_WIDTH));
    end
  end

  // fifo latency is shorter than the log2 pipeline, so a paired
  // split always has the block waiting when its position arrives
  a_split_paired: assert property (
    @(posedge clk) disable iff (rst)
    log_out_valid |-> fifo_out_valid
  ) else $error("split sent a block to one branch only");

endmodule

// ==== include/mx_cast_ref.svh ====
`ifndef MX_CAST_REF_SVH
`define MX_CAST_REF_SVH

// expected output blocks in arrival order
typedef mx_pkg::out_block_t mx_exp_queue_t[$];

// limit a value to the range of a signed field of the given width
function automatic int saturate(input int value, input int width);
  int hi;
  int lo;
  hi = 2 ** (width - 1) - 1;
  lo = -(2 ** (width - 1));
  if (value > hi) begin
    return hi;
  end
  if (value < lo) begin
    return lo;
  end
  return value;
endfunction

// leading-one position of the largest magnitude, 0 for an all-zero block
function automatic int largest_log2(input mx_pkg::in_block_t blk);
  int max_abs;
  int v;
  int p;
  max_abs = 0;
  for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
    v = int'(blk.man[i]);
    if (v < 0) begin
      v = -v;
    end
    if (v > max_abs) begin
      max_abs = v;
    end
  end
  p = 0;
  for (int b = 0; b < mx_pkg::IN_MAN_WIDTH; b++) begin
    if (max_abs[b]) begin
      p = b;
    end
  end
  return p;
endfunction

// full cast of one block with plain integer arithmetic
function automatic mx_pkg::out_block_t expected_block(input mx_pkg::in_block_t blk);
  mx_pkg::out_block_t res;
  int exp_in;
  int exp_out;
  int shift;
  int man;
  exp_in  = int'(blk.exp);
  exp_out = saturate(largest_log2(blk) + exp_in - mx_pkg::IN_MAN_FRAC_WIDTH,
                     mx_pkg::OUT_EXP_WIDTH);
  shift   = exp_out - exp_in + mx_pkg::IN_MAN_FRAC_WIDTH - (mx_pkg::OUT_MAN_WIDTH - 1);
  for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
    man = int'(blk.man[i]);
    if (shift >= 0) begin
      man = man >>> shift;
    end else begin
      man = man <<< -shift;
    end
    res.man[i] = mx_pkg::out_man_t'(saturate(man, mx_pkg::OUT_MAN_WIDTH));
  end
  res.exp = mx_pkg::out_exp_t'(exp_out);
  return res;
endfunction

`endif

// ==== testbench/tb_mx_cast.sv ====
`timescale 1ns/1ps

module tb_mx_cast;

  `include "mx_cast_ref.svh"

  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_BLOCKS = 200;
  localparam int EDGE_BLOCKS = 40;
  localparam int TOTAL_BLOCKS = 2 * RANDOM_BLOCKS + 2 * EDGE_BLOCKS;
  localparam int TIMEOUT_CYCLES = TOTAL_BLOCKS * 20 + RESET_CYCLES;

  logic               clk = 1'b0;
  logic               rst;
  logic               in_valid;
  logic               in_ready;
  mx_pkg::in_block_t  in_block;
  logic               out_valid;
  logic               out_ready;
  mx_pkg::out_block_t out_block;

  integer             seed;
  int                 cycle;
  mx_exp_queue_t      exp_q;
  int                 acc_cycle_q[$];
  mx_pkg::out_block_t exp_head;
  logic               head_avail;
  int                 head_cycle;
  logic               accepted;
  logic               idle_check;
  logic               latency_check;
  logic               random_ready;
  logic               saw_in_stall;
  int                 data_errs;
  int                 latency_errs;
  int                 proto_errs;

  always #2 clk = ~clk;

  mx_cast_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_block  (in_block),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block)
  );

  // scoreboard, pop before push so an empty queue never pairs with a new entry
  always @(posedge clk) begin
    cycle <= cycle + 1;
    accepted = !rst && in_valid && in_ready;
    if (!rst && out_valid && out_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      void'(acc_cycle_q.pop_front());
    end
    if (accepted) begin
      exp_q.push_back(expected_block(in_block));
      acc_cycle_q.push_back(cycle);
    end
    if (!rst && random_ready && !in_ready) begin
      saw_in_stall = 1'b1;
    end
  end

  // queue head held steady across the next rising edge
  always @(negedge clk) begin
    head_avail = (exp_q.size() > 0);
    if (exp_q.size() > 0) begin
      exp_head   = exp_q[0];
      head_cycle = acc_cycle_q[0];
    end
  end

  a_known: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && out_ready) |-> head_avail
  ) else begin
    proto_errs++;
    $display("an output block appeared at %0t with no input block in flight", $time);
  end

  a_data: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && out_ready && head_avail) |-> (out_block == exp_head)
  ) else begin
    data_errs++;
    $display("ERROR %0t: block mismatch, got %h expected %h", $time,
             $sampled(out_block), $sampled(exp_head));
  end

  a_latency: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && out_ready && head_avail && latency_check) |-> (cycle == head_cycle + 3)
  ) else begin
    latency_errs++;
    $display("ERROR %0t: output after %0d cycles, expected 3", $time,
             $sampled(cycle) - $sampled(head_cycle));
  end

  a_stall: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_block))
  ) else begin
    proto_errs++;
    $display("the output block changed or was dropped while stalled at %0t", $time);
  end

  a_idle: assert property (
    @(posedge clk) disable iff (rst)
    idle_check |-> (!out_valid && in_ready)
  ) else begin
    proto_errs++;
    $display("the idle DUT was not ready or showed a valid output at %0t", $time);
  end

  // one falling edge, out_ready redrawn here to keep the random stream in order
  task automatic next_cycle();
    int r;
    @(negedge clk);
    r = $random(seed);
    out_ready = random_ready ? r[0] : 1'b1;
  endtask

  task automatic send_block(input mx_pkg::in_block_t blk);
    in_valid = 1'b1;
    in_block = blk;
    do begin
      next_cycle();
    end while (!accepted);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() > 0) begin
      next_cycle();
    end
  endtask

  // mode 0 random, 1 exponent near a limit, 2 zero block, 3 high exponent
  task automatic make_block(output mx_pkg::in_block_t blk, input int mode);
    int r;
    for (int i = 0; i < mx_pkg::BLOCK_SIZE; i++) begin
      r = $random(seed);
      blk.man[i] = (mode == 2) ? '0 : mx_pkg::in_man_t'(r);
    end
    r = $random(seed);
    blk.exp = mx_pkg::in_exp_t'(r);
    if (mode == 1) begin
      blk.exp = r[0] ? mx_pkg::in_exp_t'(31 - int'(r[2:1]))
                     : mx_pkg::in_exp_t'(-32 + int'(r[2:1]));
    end else if (mode == 3) begin
      blk.exp = mx_pkg::in_exp_t'(31);
    end
  endtask

  initial begin
    mx_pkg::in_block_t blk;
    seed = 32'hb5bc;
    rst = 1'b1;
    in_valid = 1'b0;
    in_block = '0;
    out_ready = 1'b1;
    cycle = 0;
    accepted = 1'b0;
    head_avail = 1'b0;
    exp_head = '0;
    head_cycle = 0;
    idle_check = 1'b0;
    latency_check = 1'b0;
    random_ready = 1'b0;
    saw_in_stall = 1'b0;
    data_errs = 0;
    latency_errs = 0;
    proto_errs = 0;
    repeat (RESET_CYCLES) next_cycle();
    rst = 1'b0;
    idle_check = 1'b1;
    repeat (10) next_cycle();
    idle_check = 1'b0;
    // full rate stream
    latency_check = 1'b1;
    for (int n = 0; n < RANDOM_BLOCKS; n++) begin
      make_block(blk, 0);
      send_block(blk);
    end
    drain();
    latency_check = 1'b0;
    // random back-pressure
    random_ready = 1'b1;
    for (int n = 0; n < RANDOM_BLOCKS; n++) begin
      make_block(blk, 0);
      send_block(blk);
    end
    drain();
    random_ready = 1'b0;
    // exponent limits, then zero blocks mixed with saturating mantissas
    for (int n = 0; n < EDGE_BLOCKS; n++) begin
      make_block(blk, 1);
      send_block(blk);
    end
    for (int n = 0; n < EDGE_BLOCKS; n++) begin
      make_block(blk, (n % 2 == 0) ? 2 : 3);
      send_block(blk);
    end
    drain();
    repeat (10) next_cycle();
    a_backpressure: assert (saw_in_stall) else begin
      proto_errs++;
      $display("in_ready never went low while the output was stalled");
    end
    $display("errors: data=%0d latency=%0d protocol=%0d", data_errs, latency_errs, proto_errs);
    if (data_errs + latency_errs + proto_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
